//--- bench/pwr_manager_asserts.sv
/* Checks on the AXI response handshake and on the domain output ordering.
   The checks are off while the system reset is asserted. */
module pwr_manager_asserts (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       s_bvalid_o,
  input logic       s_bready_i,
  input logic       s_rvalid_o,
  input logic       s_rready_i,
  input logic [3:0] pwr_switch_off_o,
  input logic [3:0] iso_en_o,
  input logic [3:0] dom_rst_n_o,
  input logic [3:0] clk_gate_en_o
);

  // a response is held until the master takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o)
    else $error("bvalid dropped before bready");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o)
    else $error("rvalid dropped before rready");

  for (genvar d = 0; d < 4; d++) begin : g_dom
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pwr_switch_off_o[d] |-> iso_en_o[d])
      else $error("domain %0d switch open without isolation", d);

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(clk_gate_en_o[d]) |-> dom_rst_n_o[d])
      else $error("domain %0d clock ungated while in reset", d);
  end

endmodule

bind pwr_manager pwr_manager_asserts i_pwr_manager_asserts (
  .clk_i(clk_i), .rst_n_i(rst_n_i),
  .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
  .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
  .pwr_switch_off_o(pwr_switch_off_o), .iso_en_o(iso_en_o),
  .dom_rst_n_o(dom_rst_n_o), .clk_gate_en_o(clk_gate_en_o)
);

//--- bench/tb_clock.sv
/* Free-running testbench clock and a reset that is held low for RST_CYCLES rising edges. */
module tb_clock #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  logic clk = 1'b0;

  assign clk_o = clk;

  always begin
    #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n_o <= 1'b1;
  end

endmodule

//--- bench/tb_pwr_manager.sv
/* Directed tests of the power manager over AXI4-Lite, with a switch-ack model.
   Output changes are logged at the falling edge and checked per sequence. */
module tb_pwr_manager;

  localparam int ACK_LAT = 3;
  localparam int LIMIT   = 3000;

  logic clk;
  logic rst_n;
  logic [7:0] awaddr;
  logic [7:0] araddr;
  logic awvalid;
  logic wvalid;
  logic bready;
  logic arvalid;
  logic rready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic awready;
  logic wready;
  logic bvalid;
  logic arready;
  logic rvalid;
  logic [1:0] bresp;
  logic [1:0] rresp;
  logic [31:0] rdata;
  logic [7:0] irq;
  logic [3:0] ack = 4'hf;
  logic [3:0] sw;
  logic [3:0] iso;
  logic [3:0] drst_n;
  logic [3:0] cg;
  logic [ACK_LAT-1:0] ack_pipe [4] = '{default: '1};
  logic [3:0] prev_sw;
  logic [3:0] prev_iso;
  logic [3:0] prev_rst;
  logic [3:0] prev_cg;
  logic [31:0] rng = 32'hf61bea57;
  logic [3:0] on_exp = 4'hf;
  int cyc = 0;
  int errors = 0;
  int timeouts = 0;
  int dly = 4;
  int ev_kind[$];
  int ev_dom[$];
  int ev_val[$];
  int ev_cyc[$];

  tb_clock #(.PERIOD(8), .RST_CYCLES(8)) i_tb_clock (.clk_o(clk), .rst_n_o(rst_n));

  pwr_manager i_pwr_manager (
    .clk_i(clk), .rst_n_i(rst_n),
    .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
    .s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wvalid_i(wvalid), .s_wready_o(wready),
    .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
    .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
    .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
    .irq_i(irq), .pwr_ack_i(ack),
    .pwr_switch_off_o(sw), .iso_en_o(iso), .dom_rst_n_o(drst_n), .clk_gate_en_o(cg)
  );

  // ack follows the closed switch a few cycles later
  always @(posedge clk) begin
    cyc <= cyc + 1;
    for (int d = 0; d < 4; d++) begin
      ack_pipe[d] <= {ack_pipe[d][ACK_LAT-2:0], !sw[d]};
      ack[d]      <= ack_pipe[d][ACK_LAT-1];
    end
  end

  // event kind 0 is the clock gate, 1 isolation, 2 reset and 3 the switch
  task automatic log_event(input int kind, input int dom, input logic val);
    ev_kind.push_back(kind);
    ev_dom.push_back(dom);
    ev_val.push_back(int'(val));
    ev_cyc.push_back(cyc);
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      for (int d = 0; d < 4; d++) begin
        if (cg[d] !== prev_cg[d]) log_event(0, d, cg[d]);
        if (iso[d] !== prev_iso[d]) log_event(1, d, iso[d]);
        if (drst_n[d] !== prev_rst[d]) log_event(2, d, drst_n[d]);
        if (sw[d] !== prev_sw[d]) log_event(3, d, sw[d]);
      end
    end
    prev_cg  <= cg;
    prev_iso <= iso;
    prev_rst <= drst_n;
    prev_sw  <= sw;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int exp_kind(input logic up, input int i);
    return up ? 3 - i : i;
  endfunction

  // reset is active low and every other output active high
  function automatic int exp_val(input logic up, input int kind);
    return (kind == 2) ? int'(up) : int'(!up);
  endfunction

  task automatic clear_events();
    ev_kind.delete();
    ev_dom.delete();
    ev_val.delete();
    ev_cyc.delete();
  endtask

  task automatic count_error(input string msg);
    errors++;
    $display("mismatch at %0t: %s", $time, msg);
  endtask

  task automatic count_timeout(input string what);
    timeouts++;
    $display("timeout at %0t: no %s", $time, what);
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int n;
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(awready || wready) && n < LIMIT);
    if (n >= LIMIT) begin
      count_timeout("write address handshake");
    end else if (awready !== wready) begin
      count_error("awready and wready not raised together");
    end
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!bvalid && n < LIMIT);
    if (n >= LIMIT) count_timeout("write response");
    resp = bresp;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!arready && n < LIMIT);
    if (n >= LIMIT) count_timeout("read address handshake");
    @(posedge clk);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rvalid && n < LIMIT);
    if (n >= LIMIT) count_timeout("read data");
    data = rdata;
    resp = rresp;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    logic [1:0] resp;
    int n;
    n = 0;
    do begin
      axil_read(8'h00, st, resp);
      n++;
    end while (st[31] && n < LIMIT);
    if (n >= LIMIT) count_timeout("return to idle");
  endtask

  task automatic check_status();
    logic [31:0] st;
    logic [1:0] resp;
    axil_read(8'h00, st, resp);
    if (st !== {28'h0, on_exp} || resp !== 2'b00)
      count_error($sformatf("STATUS %h resp %0d, expected %h", st, resp, on_exp));
  endtask

  // the four output changes of one sequence and their spacing
  task automatic check_events(input int dom, input logic up);
    if (ev_kind.size() != 4) begin
      count_error($sformatf("%0d output changes for domain %0d, expected 4",
                            ev_kind.size(), dom));
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (ev_dom[i] != dom || ev_kind[i] != exp_kind(up, i) ||
            ev_val[i] != exp_val(up, exp_kind(up, i)))
          count_error($sformatf("step %0d: dom %0d kind %0d val %0d", i, ev_dom[i],
                                ev_kind[i], ev_val[i]));
      end
      for (int i = (up ? 2 : 1); i < 4; i++) begin
        if (ev_cyc[i] - ev_cyc[i-1] != dly)
          count_error($sformatf("step %0d spacing %0d, expected %0d", i,
                                ev_cyc[i] - ev_cyc[i-1], dly));
      end
    end
  endtask

  task automatic run_sequence(input int dom, input logic up);
    logic [1:0] resp;
    clear_events();
    axil_write(8'h04, (up ? 32'h100 : 32'h0) | 32'(dom), resp);
    if (resp !== 2'b00) count_error("CMD write not answered OKAY");
    wait_idle();
    on_exp[dom] = up;
    check_events(dom, up);
    check_status();
  endtask

  task automatic check_outputs_reset();
    @(negedge clk);
    if (sw !== 4'h0 || iso !== 4'h0 || cg !== 4'h0 || drst_n !== 4'hf)
      count_error($sformatf("outputs sw %h iso %h cg %h rst_n %h", sw, iso, cg, drst_n));
  endtask

  task automatic test_reset();
    logic [31:0] d;
    logic [1:0] resp;
    check_status();
    axil_read(8'h08, d, resp);
    if (d !== 32'd4 || resp !== 2'b00)
      count_error($sformatf("DELAY reads %0d resp %0d after reset", d, resp));
    check_outputs_reset();
  endtask

  task automatic test_down_up();
    int dom;
    dom = int'(next_rand() % 4);
    run_sequence(dom, 1'b0);
    run_sequence(dom, 1'b1);
    check_outputs_reset();
  endtask

  task automatic test_random_delay();
    logic [31:0] d;
    logic [31:0] val;
    logic [1:0] resp;
    int dom;
    val = (next_rand() % 255) + 1;
    axil_write(8'h08, val, resp);
    if (resp !== 2'b00) count_error("DELAY write not answered OKAY");
    axil_read(8'h08, d, resp);
    if (d !== val || resp !== 2'b00)
      count_error($sformatf("DELAY reads back %0d resp %0d, expected %0d", d, resp, val));
    dly = int'(d);
    dom = int'(next_rand() % 4);
    run_sequence(dom, 1'b0);
    run_sequence(dom, 1'b1);
  endtask

  task automatic test_errors();
    logic [31:0] d;
    logic [1:0] resp;
    int a;
    axil_write(8'h08, 32'd16, resp);
    dly = 16;
    a = int'(next_rand() % 4);
    clear_events();
    axil_write(8'h04, 32'(a), resp);
    if (resp !== 2'b00) count_error("CMD write while idle not answered OKAY");
    axil_write(8'h04, 32'h100 | 32'((a + 1) % 4), resp);
    if (resp !== 2'b10) count_error("CMD write while busy not answered SLVERR");
    wait_idle();
    on_exp[a] = 1'b0;
    check_events(a, 1'b0);
    check_status();
    run_sequence(a, 1'b1);
    axil_write(8'h40, 32'hffff_ffff, resp);
    if (resp !== 2'b10) count_error("unmapped write not answered SLVERR");
    axil_read(8'h40, d, resp);
    if (resp !== 2'b10 || d !== 32'h0)
      count_error($sformatf("unmapped read data %h resp %0d", d, resp));
  endtask

  task automatic test_wake();
    logic [31:0] st;
    logic [1:0] resp;
    int w;
    int mb;
    int ob;
    int n;
    w  = int'(next_rand() % 4);
    mb = int'(next_rand() % 8);
    ob = (mb + 1) % 8;
    axil_write(8'h10 + 8'(4 * w), 32'h1 << mb, resp);
    if (resp !== 2'b00) count_error("WAKE_MASK write not answered OKAY");
    run_sequence(w, 1'b0);
    @(posedge clk);
    irq <= 8'h1 << ob;
    repeat (40) @(posedge clk);
    check_status();
    clear_events();
    @(posedge clk);
    irq <= (8'h1 << ob) | (8'h1 << mb);
    n = 0;
    do begin
      axil_read(8'h00, st, resp);
      n++;
    end while (!st[w] && n < LIMIT);
    if (n >= LIMIT) count_timeout("wake of the masked domain");
    @(posedge clk);
    irq <= 8'h0;
    on_exp[w] = 1'b1;
    check_events(w, 1'b1);
    check_status();
  endtask

  initial begin
    int n;
    awaddr  = '0;
    araddr  = '0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    wdata   = '0;
    wstrb   = 4'hf;
    irq     = '0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!rst_n && n < LIMIT);
    if (n >= LIMIT) count_timeout("release of reset");
    repeat (2) @(posedge clk);
    test_reset();
    test_down_up();
    test_random_delay();
    test_errors();
    test_wake();
    $display("run complete: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
verilog/pwr_pkg.sv
verilog/pwr_axil_regs.sv
verilog/pwr_seq_fsm.sv
verilog/pwr_step_timer.sv
verilog/pwr_domain_ctrl.sv
verilog/pwr_manager.sv
bench/pwr_manager_asserts.sv
bench/tb_clock.sv
bench/tb_pwr_manager.sv

//--- run.sh
#!/bin/sh
# Build and run the power manager testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_pwr_manager \
  -f project.f -o sim_pwr_manager

output=$(./obj_dir/sim_pwr_manager)
echo "$output"

if echo "$output" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1

//--- verilog/pwr_axil_regs.sv
/* AXI4-Lite slave of the power manager. WSTRB is ignored, every write is a full word.
   Unmapped offsets answer SLVERR and read zero; a CMD write while busy is dropped. */
module pwr_axil_regs (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [pwr_pkg::ADDR_W-1:0]                            s_awaddr_i,
  input  logic                                                  s_awvalid_i,
  output logic                                                  s_awready_o,
  input  logic [pwr_pkg::DATA_W-1:0]                            s_wdata_i,
  input  logic [pwr_pkg::DATA_W/8-1:0]                          s_wstrb_i,
  input  logic                                                  s_wvalid_i,
  output logic                                                  s_wready_o,
  output logic [1:0]                                            s_bresp_o,
  output logic                                                  s_bvalid_o,
  input  logic                                                  s_bready_i,
  input  logic [pwr_pkg::ADDR_W-1:0]                            s_araddr_i,
  input  logic                                                  s_arvalid_i,
  output logic                                                  s_arready_o,
  output logic [pwr_pkg::DATA_W-1:0]                            s_rdata_o,
  output logic [1:0]                                            s_rresp_o,
  output logic                                                  s_rvalid_o,
  input  logic                                                  s_rready_i,
  input  logic                                                  busy_i,
  input  logic [pwr_pkg::NUM_DOMAINS-1:0]                       dom_on_i,
  output logic [pwr_pkg::DELAY_W-1:0]                           delay_o,
  output logic [pwr_pkg::NUM_DOMAINS-1:0][pwr_pkg::NUM_IRQ-1:0] wake_mask_o,
  output logic                                                  cmd_valid_o,
  output logic [pwr_pkg::DOM_W-1:0]                             cmd_dom_o,
  output pwr_pkg::pwr_op_e                                      cmd_op_o
);

  logic                      wr_hs;
  logic                      rd_hs;
  logic                      wr_cmd;
  logic                      wr_delay;
  logic                      wr_wake;
  logic                      wr_ok;
  logic                      rd_ok;
  logic [pwr_pkg::DATA_W-1:0] rd_data;

  // wake masks sit at one word per domain from the base
  function automatic logic is_wake(input logic [pwr_pkg::ADDR_W-1:0] addr);
    return {addr[pwr_pkg::ADDR_W-1:pwr_pkg::DOM_W+2], {pwr_pkg::DOM_W{1'b0}}, addr[1:0]}
           == pwr_pkg::REG_WAKE_BASE;
  endfunction

  // AW and W are taken in one handshake
  assign wr_hs       = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
  assign s_awready_o = wr_hs;
  assign s_wready_o  = wr_hs;

  assign wr_cmd   = (s_awaddr_i == pwr_pkg::REG_CMD);
  assign wr_delay = (s_awaddr_i == pwr_pkg::REG_DELAY);
  assign wr_wake  = is_wake(s_awaddr_i);
  assign wr_ok    = wr_delay || wr_wake || (wr_cmd && !busy_i);

  assign cmd_valid_o = wr_hs && wr_cmd && !busy_i;
  assign cmd_dom_o   = s_wdata_i[pwr_pkg::DOM_W-1:0];
  assign cmd_op_o    = pwr_pkg::pwr_op_e'(s_wdata_i[pwr_pkg::CMD_OP_BIT]);

  assign s_arready_o = !s_rvalid_o;
  assign rd_hs       = s_arvalid_i && s_arready_o;

  always_comb begin
    rd_data = '0;
    rd_ok   = 1'b1;
    if (s_araddr_i == pwr_pkg::REG_STATUS) begin
      rd_data[pwr_pkg::NUM_DOMAINS-1:0]  = dom_on_i;
      rd_data[pwr_pkg::STATUS_BUSY_BIT] = busy_i;
    end else if (s_araddr_i == pwr_pkg::REG_DELAY) begin
      rd_data[pwr_pkg::DELAY_W-1:0] = delay_o;
    end else if (is_wake(s_araddr_i)) begin
      rd_data[pwr_pkg::NUM_IRQ-1:0] = wake_mask_o[s_araddr_i[pwr_pkg::DOM_W+1:2]];
    end else begin
      rd_ok = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s_bvalid_o  <= 1'b0;
      s_rvalid_o  <= 1'b0;
      delay_o     <= pwr_pkg::DEFAULT_DELAY;
      wake_mask_o <= '0;
    end else begin
      if (wr_hs) begin
        s_bvalid_o <= 1'b1;
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
      if (rd_hs) begin
        s_rvalid_o <= 1'b1;
      end else if (s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
      if (wr_hs && wr_delay) begin
        delay_o <= (s_wdata_i[pwr_pkg::DELAY_W-1:0] == '0) ? pwr_pkg::DELAY_MIN :
                   s_wdata_i[pwr_pkg::DELAY_W-1:0];
      end
      if (wr_hs && wr_wake) begin
        wake_mask_o[s_awaddr_i[pwr_pkg::DOM_W+1:2]] <= s_wdata_i[pwr_pkg::NUM_IRQ-1:0];
      end
    end
  end

  // payload loads at the handshake and holds while its valid is high
  always_ff @(posedge clk_i) begin
    if (wr_hs) begin
      s_bresp_o <= wr_ok ? pwr_pkg::RESP_OKAY : pwr_pkg::RESP_SLVERR;
    end
    if (rd_hs) begin
      s_rdata_o <= rd_data;
      s_rresp_o <= rd_ok ? pwr_pkg::RESP_OKAY : pwr_pkg::RESP_SLVERR;
    end
  end

endmodule

//--- verilog/pwr_domain_ctrl.sv
/* Per-domain switch, isolation, reset and clock gate registers, plus the wake request.
   Domain resets are held through system reset and released on the first clock after it. */
module pwr_domain_ctrl (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [pwr_pkg::NUM_IRQ-1:0]                           irq_i,
  input  logic [pwr_pkg::NUM_DOMAINS-1:0][pwr_pkg::NUM_IRQ-1:0] wake_mask_i,
  input  logic [pwr_pkg::DOM_W-1:0]                             dom_i,
  input  pwr_pkg::pwr_op_e                                      op_i,
  input  logic                                                  step_valid_i,
  input  pwr_pkg::pwr_step_e                                    step_i,
  input  logic                                                  seq_done_i,
  input  logic                                                  busy_i,
  input  logic [pwr_pkg::NUM_DOMAINS-1:0]                       pwr_ack_i,
  output logic                                                  sel_ack_o,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]                       dom_on_o,
  output logic                                                  wake_req_o,
  output logic [pwr_pkg::DOM_W-1:0]                             wake_dom_o,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]                       pwr_switch_off_o,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]                       iso_en_o,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]                       dom_rst_n_o,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]                       clk_gate_en_o
);

  logic                              init_done_q;
  logic                              down;
  logic [pwr_pkg::NUM_DOMAINS-1:0]   wake_cand;

  assign down      = (op_i == pwr_pkg::OP_DOWN);
  assign sel_ack_o = pwr_ack_i[dom_i];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      init_done_q      <= 1'b0;
      pwr_switch_off_o <= '0;
      iso_en_o         <= '0;
      dom_rst_n_o      <= '0;
      clk_gate_en_o    <= '0;
      dom_on_o         <= '1;
    end else begin
      init_done_q <= 1'b1;
      if (!init_done_q) begin
        dom_rst_n_o <= '1;
      end
      // one step strobe touches the selected domain only
      if (step_valid_i) begin
        case (step_i)
          pwr_pkg::STEP_CLK:    clk_gate_en_o[dom_i]    <= down;
          pwr_pkg::STEP_ISO:    iso_en_o[dom_i]         <= down;
          pwr_pkg::STEP_RST:    dom_rst_n_o[dom_i]      <= !down;
          pwr_pkg::STEP_SWITCH: pwr_switch_off_o[dom_i] <= down;
          default:              ;
        endcase
      end
      if (seq_done_i) begin
        dom_on_o[dom_i] <= !down;
      end
    end
  end

  // lowest masked wake domain is picked
  always_comb begin
    wake_dom_o = '0;
    for (int d = 0; d < pwr_pkg::NUM_DOMAINS; d++) begin
      wake_cand[d] = !dom_on_o[d] && |(irq_i & wake_mask_i[d]);
    end
    for (int d = pwr_pkg::NUM_DOMAINS - 1; d >= 0; d--) begin
      if (wake_cand[d]) begin
        wake_dom_o = d[pwr_pkg::DOM_W-1:0];
      end
    end
  end

  assign wake_req_o = |wake_cand && !busy_i;

endmodule

//--- verilog/pwr_manager.sv
/* Always-on power manager for four switchable domains behind an AXI4-Lite slave.
   pwr_ack_i is high while a domain is powered; a missing ack stalls the manager. */
module pwr_manager (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [pwr_pkg::ADDR_W-1:0]          s_awaddr_i,
  input  logic                                s_awvalid_i,
  output logic                                s_awready_o,
  input  logic [pwr_pkg::DATA_W-1:0]          s_wdata_i,
  input  logic [pwr_pkg::DATA_W/8-1:0]        s_wstrb_i,
  input  logic                                s_wvalid_i,
  output logic                                s_wready_o,
  output logic [1:0]                          s_bresp_o,
  output logic                                s_bvalid_o,
  input  logic                                s_bready_i,
  input  logic [pwr_pkg::ADDR_W-1:0]          s_araddr_i,
  input  logic                                s_arvalid_i,
  output logic                                s_arready_o,
  output logic [pwr_pkg::DATA_W-1:0]          s_rdata_o,
  output logic [1:0]                          s_rresp_o,
  output logic                                s_rvalid_o,
  input  logic                                s_rready_i,
  input  logic [pwr_pkg::NUM_IRQ-1:0]         irq_i,
  input  logic [pwr_pkg::NUM_DOMAINS-1:0]     pwr_ack_i,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]     pwr_switch_off_o,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]     iso_en_o,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]     dom_rst_n_o,
  output logic [pwr_pkg::NUM_DOMAINS-1:0]     clk_gate_en_o
);

  logic                                                  busy;
  logic [pwr_pkg::NUM_DOMAINS-1:0]                       dom_on;
  logic [pwr_pkg::DELAY_W-1:0]                           delay;
  logic [pwr_pkg::NUM_DOMAINS-1:0][pwr_pkg::NUM_IRQ-1:0] wake_mask;
  logic                                                  cmd_valid;
  logic [pwr_pkg::DOM_W-1:0]                             cmd_dom;
  pwr_pkg::pwr_op_e                                      cmd_op;
  logic                                                  wake_req;
  logic [pwr_pkg::DOM_W-1:0]                             wake_dom;
  logic                                                  sel_ack;
  logic                                                  timer_start;
  logic                                                  timer_done;
  logic [pwr_pkg::DOM_W-1:0]                             seq_dom;
  pwr_pkg::pwr_op_e                                      seq_op;
  logic                                                  step_valid;
  pwr_pkg::pwr_step_e                                    step;
  logic                                                  seq_done;

  pwr_axil_regs i_pwr_axil_regs (
    .clk_i, .rst_n_i,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o,
    .s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
    .s_bresp_o, .s_bvalid_o, .s_bready_i,
    .s_araddr_i, .s_arvalid_i, .s_arready_o,
    .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .busy_i(busy), .dom_on_i(dom_on), .delay_o(delay), .wake_mask_o(wake_mask),
    .cmd_valid_o(cmd_valid), .cmd_dom_o(cmd_dom), .cmd_op_o(cmd_op)
  );

  pwr_seq_fsm i_pwr_seq_fsm (
    .clk_i, .rst_n_i,
    .cmd_valid_i(cmd_valid), .cmd_dom_i(cmd_dom), .cmd_op_i(cmd_op),
    .wake_req_i(wake_req), .wake_dom_i(wake_dom),
    .sel_ack_i(sel_ack), .timer_done_i(timer_done),
    .busy_o(busy), .dom_o(seq_dom), .op_o(seq_op),
    .step_valid_o(step_valid), .step_o(step),
    .timer_start_o(timer_start), .seq_done_o(seq_done)
  );

  pwr_step_timer i_pwr_step_timer (
    .clk_i, .rst_n_i,
    .start_i(timer_start), .delay_i(delay), .done_o(timer_done)
  );

  pwr_domain_ctrl i_pwr_domain_ctrl (
    .clk_i, .rst_n_i,
    .irq_i, .wake_mask_i(wake_mask),
    .dom_i(seq_dom), .op_i(seq_op),
    .step_valid_i(step_valid), .step_i(step),
    .seq_done_i(seq_done), .busy_i(busy), .pwr_ack_i,
    .sel_ack_o(sel_ack), .dom_on_o(dom_on),
    .wake_req_o(wake_req), .wake_dom_o(wake_dom),
    .pwr_switch_off_o, .iso_en_o, .dom_rst_n_o, .clk_gate_en_o
  );

endmodule

//--- verilog/pwr_pkg.sv
/* Shared sizes, register map and encodings of the power manager.
   Four domains and eight wake lines; resizing needs the CMD and WAKE decode rechecked. */
package pwr_pkg;

  localparam int NUM_DOMAINS = 4;
  localparam int DOM_W       = 2;
  localparam int NUM_IRQ     = 8;

  localparam int ADDR_W  = 8;
  localparam int DATA_W  = 32;
  localparam int DELAY_W = 8;

  localparam logic [DELAY_W-1:0] DEFAULT_DELAY = 8'd4;
  // a zero delay write is stored as this
  localparam logic [DELAY_W-1:0] DELAY_MIN = 8'd1;

  // register byte offsets
  localparam logic [ADDR_W-1:0] REG_STATUS    = 8'h00;
  localparam logic [ADDR_W-1:0] REG_CMD       = 8'h04;
  localparam logic [ADDR_W-1:0] REG_DELAY     = 8'h08;
  localparam logic [ADDR_W-1:0] REG_WAKE_BASE = 8'h10;

  localparam int STATUS_BUSY_BIT = 31;
  localparam int CMD_OP_BIT      = 8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic {
    OP_DOWN = 1'b0,
    OP_UP   = 1'b1
  } pwr_op_e;

  // a busy state names the last step that was issued
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CLK,
    ST_ISO,
    ST_RST,
    ST_SWITCH
  } pwr_state_e;

  typedef enum logic [1:0] {
    STEP_CLK,
    STEP_ISO,
    STEP_RST,
    STEP_SWITCH
  } pwr_step_e;

endpackage

//--- verilog/pwr_seq_fsm.sv
/* Power step sequencer, one sequence at a time. The first step is issued in the cycle of
   the command or wake. The switch step waits on the ack level with no timeout. */
module pwr_seq_fsm (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      cmd_valid_i,
  input  logic [pwr_pkg::DOM_W-1:0] cmd_dom_i,
  input  pwr_pkg::pwr_op_e          cmd_op_i,
  input  logic                      wake_req_i,
  input  logic [pwr_pkg::DOM_W-1:0] wake_dom_i,
  input  logic                      sel_ack_i,
  input  logic                      timer_done_i,
  output logic                      busy_o,
  output logic [pwr_pkg::DOM_W-1:0] dom_o,
  output pwr_pkg::pwr_op_e          op_o,
  output logic                      step_valid_o,
  output pwr_pkg::pwr_step_e        step_o,
  output logic                      timer_start_o,
  output logic                      seq_done_o
);

  pwr_pkg::pwr_state_e       state_q;
  pwr_pkg::pwr_state_e       state_d;
  logic [pwr_pkg::DOM_W-1:0] dom_q;
  pwr_pkg::pwr_op_e          op_q;
  logic                      start;
  logic [pwr_pkg::DOM_W-1:0] dom_sel;
  pwr_pkg::pwr_op_e          op_sel;
  logic                      down;

  // command wins over a wake in the same cycle
  assign start   = (state_q == pwr_pkg::ST_IDLE) && (cmd_valid_i || wake_req_i);
  assign dom_sel = cmd_valid_i ? cmd_dom_i : wake_dom_i;
  assign op_sel  = cmd_valid_i ? cmd_op_i : pwr_pkg::OP_UP;

  assign busy_o = (state_q != pwr_pkg::ST_IDLE);
  assign dom_o  = busy_o ? dom_q : dom_sel;
  assign op_o   = busy_o ? op_q : op_sel;
  assign down   = (op_o == pwr_pkg::OP_DOWN);

  always_comb begin
    state_d       = state_q;
    step_valid_o  = 1'b0;
    step_o        = pwr_pkg::STEP_CLK;
    timer_start_o = 1'b0;
    seq_done_o    = 1'b0;
    case (state_q)
      pwr_pkg::ST_IDLE: begin
        if (start) begin
          step_valid_o = 1'b1;
          if (down) begin
            step_o        = pwr_pkg::STEP_CLK;
            timer_start_o = 1'b1;
            state_d       = pwr_pkg::ST_CLK;
          end else begin
            step_o  = pwr_pkg::STEP_SWITCH;
            state_d = pwr_pkg::ST_SWITCH;
          end
        end
      end
      // only reached going down
      pwr_pkg::ST_CLK: begin
        if (timer_done_i) begin
          step_valid_o  = 1'b1;
          step_o        = pwr_pkg::STEP_ISO;
          timer_start_o = 1'b1;
          state_d       = pwr_pkg::ST_ISO;
        end
      end
      pwr_pkg::ST_ISO: begin
        if (timer_done_i) begin
          step_valid_o = 1'b1;
          if (down) begin
            step_o        = pwr_pkg::STEP_RST;
            timer_start_o = 1'b1;
            state_d       = pwr_pkg::ST_RST;
          end else begin
            // clock gate drop ends a power-up
            step_o     = pwr_pkg::STEP_CLK;
            seq_done_o = 1'b1;
            state_d    = pwr_pkg::ST_IDLE;
          end
        end
      end
      pwr_pkg::ST_RST: begin
        if (timer_done_i) begin
          step_valid_o = 1'b1;
          if (down) begin
            step_o  = pwr_pkg::STEP_SWITCH;
            state_d = pwr_pkg::ST_SWITCH;
          end else begin
            step_o        = pwr_pkg::STEP_ISO;
            timer_start_o = 1'b1;
            state_d       = pwr_pkg::ST_ISO;
          end
        end
      end
      pwr_pkg::ST_SWITCH: begin
        if (down && !sel_ack_i) begin
          seq_done_o = 1'b1;
          state_d    = pwr_pkg::ST_IDLE;
        end else if (!down && sel_ack_i) begin
          step_valid_o  = 1'b1;
          step_o        = pwr_pkg::STEP_RST;
          timer_start_o = 1'b1;
          state_d       = pwr_pkg::ST_RST;
        end
      end
      default: state_d = pwr_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= pwr_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // target of the running sequence
  always_ff @(posedge clk_i) begin
    if (start) begin
      dom_q <= dom_sel;
      op_q  <= op_sel;
    end
  end

endmodule

//--- verilog/pwr_step_timer.sv
/* Step delay counter. done_o pulses exactly delay_i cycles after start_i;
   a new start_i reloads the count. delay_i must be at least 1. */
module pwr_step_timer (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        start_i,
  input  logic [pwr_pkg::DELAY_W-1:0] delay_i,
  output logic                        done_o
);

  logic [pwr_pkg::DELAY_W-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= delay_i;
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - pwr_pkg::DELAY_MIN;
    end
  end

  // last counted cycle
  assign done_o = (cnt_q == pwr_pkg::DELAY_MIN);

endmodule
